// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scope_capture
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== capture_pkg.sv ====
package capture_pkg;

  // segment counter width of the num_segments input
  localparam int SEG_CNT_W = 5;

  // hard ceiling on segments per capture
  localparam logic [SEG_CNT_W-1:0] MAX_SEGMENTS = 5'd16;

  // segment writer states
  typedef enum logic [1:0] {
    WR_IDLE    = 2'd0,  // no capture running, address restarts at 0
    WR_WAIT_GO = 2'd1,  // between segments
    WR_WRITE   = 2'd2,  // burst in progress
    WR_DONE    = 2'd3   // one cycle, raises capture done
  } wr_state_e;

endpackage

// ==== host_pkg.sv ====
package host_pkg;

  // host read opcodes
  typedef enum logic [1:0] {
    OP_NOP         = 2'd0,
    OP_READ_SAMPLE = 2'd1,  // one buffer word at host_addr
    OP_READ_LENGTH = 2'd2   // trigger length counter
  } host_op_e;

  // owner of the sample buffer port this cycle
  typedef enum logic [1:0] {
    GNT_NONE   = 2'd0,
    GNT_WRITER = 2'd1,
    GNT_READER = 2'd2
  } grant_e;

endpackage

// ==== host_reader.sv ====
`timescale 1ns/1ps

module host_reader #(
  parameter int SAMPLE_W = 12,
  parameter int ADDR_W   = 10
) (
  input  logic                adc_clk,
  input  logic                reset,
  input  host_pkg::host_op_e  host_op_i,         // held until host_rvalid_o
  input  logic [ADDR_W-1:0]   host_addr_i,
  input  logic [31:0]         trigger_length_i,
  input  logic [SAMPLE_W-1:0] rd_data_i,
  input  logic                rd_valid_i,
  input  host_pkg::grant_e    rd_grant_i,        // buffer owner this cycle
  output logic                rd_req_o,
  output logic [ADDR_W-1:0]   rd_addr_o,
  output logic [31:0]         host_rdata_o,
  output logic                host_rvalid_o
);

  typedef enum logic [2:0] {
    HR_IDLE,
    HR_LEN,   // length captured, move to output
    HR_REQ,   // asking the buffer, may be refused
    HR_WAIT,  // granted, data next
    HR_RESP   // rvalid cycle
  } hr_state_e;

  hr_state_e   state;
  logic [31:0] len_q;

  assign rd_req_o      = (state == HR_REQ);
  assign host_rvalid_o = (state == HR_RESP);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state <= HR_IDLE;
    end else begin
      case (state)
        HR_IDLE: begin
          if (host_op_i == host_pkg::OP_READ_LENGTH)
            state <= HR_LEN;
          else if (host_op_i == host_pkg::OP_READ_SAMPLE)
            state <= HR_REQ;
        end
        HR_LEN:  state <= HR_RESP;
        HR_REQ:  if (rd_grant_i == host_pkg::GNT_READER) state <= HR_WAIT;
        HR_WAIT: if (rd_valid_i) state <= HR_RESP;
        default: state <= HR_IDLE;  // back to idle after rvalid
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (state == HR_IDLE) begin
      len_q     <= trigger_length_i;  // first of two length stages
      rd_addr_o <= host_addr_i;
    end
    if (state == HR_LEN)
      host_rdata_o <= len_q;
    else if (state == HR_WAIT && rd_valid_i)
      host_rdata_o <= 32'(rd_data_i);  // zero-extended sample
  end

endmodule

// ==== sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer #(
  parameter int SAMPLE_W = 12,
  parameter int ADDR_W   = 10
) (
  input  logic                adc_clk,
  input  logic                reset,
  input  logic                wr_req_i,
  input  logic [ADDR_W-1:0]   wr_addr_i,
  input  logic [SAMPLE_W-1:0] wr_data_i,
  input  logic                rd_req_i,
  input  logic [ADDR_W-1:0]   rd_addr_i,
  output host_pkg::grant_e    rd_grant_o,  // current owner of the port
  output logic [SAMPLE_W-1:0] rd_data_o,
  output logic                rd_valid_o
);

  logic [SAMPLE_W-1:0] mem [0:(1<<ADDR_W)-1];  // single port sample store

  host_pkg::grant_e grant;
  host_pkg::grant_e grant_q;  // last cycle's decision

  // writer first, reader only on idle write cycles
  always_comb begin
    if (wr_req_i)
      grant = host_pkg::GNT_WRITER;
    else if (rd_req_i)
      grant = host_pkg::GNT_READER;
    else
      grant = host_pkg::GNT_NONE;
  end

  assign rd_grant_o = grant;
  assign rd_valid_o = (grant_q == host_pkg::GNT_READER);

  // one access per cycle
  always_ff @(posedge adc_clk) begin
    if (grant == host_pkg::GNT_WRITER)
      mem[wr_addr_i] <= wr_data_i;
    else if (grant == host_pkg::GNT_READER)
      rd_data_o <= mem[rd_addr_i];  // registered read
  end

  always_ff @(posedge adc_clk) begin
    if (reset)
      grant_q <= host_pkg::GNT_NONE;
    else
      grant_q <= grant;
  end

endmodule

// ==== scope_capture_top.sv ====
`timescale 1ns/1ps

module scope_capture_top #(
  parameter int SAMPLE_W = 12,
  parameter int ADDR_W   = 10
) (
  input  logic                adc_clk,
  input  logic                reset,
  input  logic                trigger_i,
  input  logic                trigger_level_i,
  input  logic                trigger_wait_i,
  input  logic                trigger_now_i,
  input  logic                arm_i,
  input  logic [31:0]         trigger_offset_i,
  input  logic [SAMPLE_W-1:0] adc_data_i,
  input  logic [4:0]          num_segments_i,
  input  logic [ADDR_W-1:0]   samples_per_segment_i,
  input  host_pkg::host_op_e  host_op_i,
  input  logic [ADDR_W-1:0]   host_addr_i,
  output logic [31:0]         host_rdata_o,
  output logic                host_rvalid_o,
  output logic                arm_o,             // observation only
  output logic                capture_active_o,
  output logic                capture_go_o
);

  logic                capture_done;
  logic [31:0]         trigger_length;
  logic                wr_req;
  logic [ADDR_W-1:0]   wr_addr;
  logic [SAMPLE_W-1:0] wr_data;
  logic                rd_req;
  logic [ADDR_W-1:0]   rd_addr;
  logic [SAMPLE_W-1:0] rd_data;
  logic                rd_valid;
  host_pkg::grant_e    rd_grant;

  trigger_unit trigger_unit_i (
    .adc_clk          (adc_clk),
    .reset            (reset),
    .trigger_i        (trigger_i),
    .trigger_level_i  (trigger_level_i),
    .trigger_wait_i   (trigger_wait_i),
    .trigger_now_i    (trigger_now_i),
    .arm_i            (arm_i),
    .trigger_offset_i (trigger_offset_i),
    .capture_done_i   (capture_done),
    .arm_o            (arm_o),
    .capture_active_o (capture_active_o),
    .capture_go_o     (capture_go_o),
    .trigger_length_o (trigger_length)
  );

  segment_writer #(.SAMPLE_W(SAMPLE_W), .ADDR_W(ADDR_W)) segment_writer_i (
    .adc_clk               (adc_clk),
    .reset                 (reset),
    .capture_go_i          (capture_go_o),
    .adc_data_i            (adc_data_i),
    .num_segments_i        (num_segments_i),
    .samples_per_segment_i (samples_per_segment_i),
    .capture_done_o        (capture_done),
    .wr_req_o              (wr_req),
    .wr_addr_o             (wr_addr),
    .wr_data_o             (wr_data)
  );

  host_reader #(.SAMPLE_W(SAMPLE_W), .ADDR_W(ADDR_W)) host_reader_i (
    .adc_clk          (adc_clk),
    .reset            (reset),
    .host_op_i        (host_op_i),
    .host_addr_i      (host_addr_i),
    .trigger_length_i (trigger_length),
    .rd_data_i        (rd_data),
    .rd_valid_i       (rd_valid),
    .rd_grant_i       (rd_grant),
    .rd_req_o         (rd_req),
    .rd_addr_o        (rd_addr),
    .host_rdata_o     (host_rdata_o),
    .host_rvalid_o    (host_rvalid_o)
  );

  // writer and reader share the one buffer port
  sample_buffer #(.SAMPLE_W(SAMPLE_W), .ADDR_W(ADDR_W)) sample_buffer_i (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .wr_req_i   (wr_req),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .rd_req_i   (rd_req),
    .rd_addr_i  (rd_addr),
    .rd_grant_o (rd_grant),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid)
  );

endmodule

// ==== segment_writer.sv ====
`timescale 1ns/1ps

module segment_writer #(
  parameter int SAMPLE_W = 12,
  parameter int ADDR_W   = 10
) (
  input  logic                adc_clk,
  input  logic                reset,
  input  logic                capture_go_i,
  input  logic [SAMPLE_W-1:0] adc_data_i,
  input  logic [4:0]          num_segments_i,
  input  logic [ADDR_W-1:0]   samples_per_segment_i,
  output logic                capture_done_o,
  output logic                wr_req_o,
  output logic [ADDR_W-1:0]   wr_addr_o,
  output logic [SAMPLE_W-1:0] wr_data_o
);

  capture_pkg::wr_state_e state;

  logic [capture_pkg::SEG_CNT_W-1:0] seg_cnt;    // segments finished
  logic [capture_pkg::SEG_CNT_W-1:0] seg_limit;
  logic [ADDR_W-1:0]                 smp_cnt;    // samples queued this burst
  logic [ADDR_W-1:0]                 smp_limit;
  logic                              start;
  logic                              last_smp;

  // clamp to 1..MAX_SEGMENTS
  always_comb begin
    if (num_segments_i == '0)
      seg_limit = 5'd1;
    else if (num_segments_i > capture_pkg::MAX_SEGMENTS)
      seg_limit = capture_pkg::MAX_SEGMENTS;
    else
      seg_limit = num_segments_i;
  end

  assign smp_limit = (samples_per_segment_i == '0) ? ADDR_W'(1) : samples_per_segment_i;
  assign start     = capture_go_i &&
                     (state == capture_pkg::WR_IDLE || state == capture_pkg::WR_WAIT_GO);
  assign last_smp  = (smp_cnt == smp_limit);
  assign capture_done_o = (state == capture_pkg::WR_DONE);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state    <= capture_pkg::WR_IDLE;
      seg_cnt  <= '0;
      smp_cnt  <= '0;
      wr_req_o <= 1'b0;
    end else begin
      case (state)
        capture_pkg::WR_IDLE, capture_pkg::WR_WAIT_GO: begin
          if (start) begin
            if (state == capture_pkg::WR_IDLE)
              seg_cnt <= '0;
            smp_cnt  <= ADDR_W'(1);
            wr_req_o <= 1'b1;  // go-cycle sample written next cycle
            state    <= capture_pkg::WR_WRITE;
          end
        end
        capture_pkg::WR_WRITE: begin
          if (last_smp) begin
            wr_req_o <= 1'b0;
            seg_cnt  <= seg_cnt + 1'b1;
            if (seg_cnt + 1'b1 == seg_limit)
              state <= capture_pkg::WR_DONE;
            else
              state <= capture_pkg::WR_WAIT_GO;
          end else begin
            smp_cnt <= smp_cnt + 1'b1;
          end
        end
        default: state <= capture_pkg::WR_IDLE;  // done lasts one cycle
      endcase
    end
  end

  // sample and address pipeline
  always_ff @(posedge adc_clk) begin
    if (start) begin
      wr_data_o <= adc_data_i;
      wr_addr_o <= (state == capture_pkg::WR_IDLE) ? '0 : wr_addr_o + 1'b1;  // packed
    end else if (state == capture_pkg::WR_WRITE && !last_smp) begin
      wr_data_o <= adc_data_i;
      wr_addr_o <= wr_addr_o + 1'b1;
    end
  end

endmodule

// ==== tb.f ====
capture_pkg.sv
host_pkg.sv
trigger_unit.sv
segment_writer.sv
host_reader.sv
sample_buffer.sv
scope_capture_top.sv
tb_scope_capture_assert.sv
tb_scope_capture.sv

// ==== tb_scope_capture.sv ====
`timescale 1ns/1ps

module tb_scope_capture;

  localparam int SAMPLE_W  = 12;
  localparam int ADDR_W    = 10;
  localparam int WAIT_MAX  = 600;   // cycles any single wait may take
  localparam int TEST_CYC  = 6000;  // worst case per test incl readback
  localparam int NUM_TESTS = 5;
  localparam int RUN_NS    = (NUM_TESTS * TEST_CYC + 200) * 40;

  logic                adc_clk;
  logic                reset;
  logic                trigger_i;
  logic                trigger_level_i;
  logic                trigger_wait_i;
  logic                trigger_now_i;
  logic                arm_i;
  logic [31:0]         trigger_offset_i;
  logic [SAMPLE_W-1:0] adc_data_i;
  logic [4:0]          num_segments_i;
  logic [ADDR_W-1:0]   samples_per_segment_i;
  host_pkg::host_op_e  host_op_i;
  logic [ADDR_W-1:0]   host_addr_i;
  logic [31:0]         host_rdata_o;
  logic                host_rvalid_o;
  logic                arm_o;
  logic                capture_active_o;
  logic                capture_go_o;

  int   edge_n;                // rising edges since time 0
  int   model_len;             // expected trigger length
  logic arm_q;
  int   exp_mem [0:(1<<ADDR_W)-1];
  int   err_cnt;
  int   used_top;              // top of region filled by the multi-segment run
  logic lvl;
  int   off, n, segs, s, g, e0, lat, i, a;
  logic [31:0] d;

  scope_capture_top #(.SAMPLE_W(SAMPLE_W), .ADDR_W(ADDR_W)) scope_capture_top_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  // ramp source and trigger length model
  initial begin
    edge_n    = 0;
    model_len = 0;
    arm_q     = 1'b0;
    forever begin
      @(posedge adc_clk);
      edge_n = edge_n + 1;
      if (reset || (arm_i && !arm_q))
        model_len = 0;  // fresh arm clears the count
      else if (trigger_i == trigger_level_i)
        model_len = model_len + 1;
      arm_q = reset ? 1'b0 : arm_i;
      #2;
      adc_data_i = edge_n[SAMPLE_W-1:0];  // sample value = edge number
    end
  end

  initial begin
    #(RUN_NS);
    $display("timeout: the tests did not finish in the expected time");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic step(input int cnt = 1);
    repeat (cnt) begin
      @(posedge adc_clk);
      #2;
    end
  endtask

  // returns the edge after which the go pulse is high
  task automatic wait_go(output int edge_go);
    int k;
    edge_go = -1;
    for (k = 0; k < WAIT_MAX && edge_go < 0; k++) begin
      @(negedge adc_clk);
      if (capture_go_o)
        edge_go = edge_n;
    end
    if (edge_go < 0)
      abort_run("capture go pulse never arrived");
  endtask

  // capture_active_o must drop one edge after the final write
  task automatic wait_idle(input int edge_go, input int len);
    int k;
    int seen;
    seen = -1;
    for (k = 0; k < WAIT_MAX && seen < 0; k++) begin
      @(negedge adc_clk);
      if (!capture_active_o)
        seen = edge_n;
    end
    if (seen < 0)
      abort_run("capture_active_o never fell after the capture");
    check_eq("capture_active_o fall edge", seen, edge_go + len + 2);
  endtask

  task automatic host_read(input host_pkg::host_op_e op, input int addr,
                           output logic [31:0] data, output int latency);
    int t0;
    int k;
    latency   = -1;
    host_op_i   = op;
    host_addr_i = addr[ADDR_W-1:0];
    t0          = edge_n;
    for (k = 0; k < WAIT_MAX && latency < 0; k++) begin
      @(negedge adc_clk);
      if (host_rvalid_o) begin
        data    = host_rdata_o;
        latency = edge_n - t0;
      end
    end
    if (latency < 0)
      abort_run("host read got no host_rvalid_o");
    step();
    host_op_i = host_pkg::OP_NOP;  // host moves on after rvalid
  endtask

  task automatic check_length();
    logic [31:0] v;
    int          l;
    host_read(host_pkg::OP_READ_LENGTH, 0, v, l);
    check_eq("length read latency", l, 2);
    check_eq("host_rdata_o length", v, model_len);
  endtask

  task automatic record_segment(input int base, input int edge_go, input int len);
    int k;
    for (k = 0; k < len; k++)
      exp_mem[base + k] = (edge_go + k) & ((1 << SAMPLE_W) - 1);
  endtask

  task automatic verify_range(input int lo, input int hi);
    int          k;
    int          l;
    logic [31:0] v;
    for (k = lo; k < hi; k++) begin
      host_read(host_pkg::OP_READ_SAMPLE, k, v, l);
      check_eq($sformatf("host_rdata_o[%0d]", k), v, exp_mem[k]);
    end
  endtask

  // drop arm, load config, re-arm and let armed settle
  task automatic start_capture(input logic level, input logic wt, input int offset,
                               input int nseg, input int len, input logic trig_val);
    arm_i                 = 1'b0;
    trigger_i             = trig_val;
    trigger_now_i         = 1'b0;
    trigger_level_i       = level;
    trigger_wait_i        = wt;
    trigger_offset_i      = offset;
    num_segments_i        = nseg[4:0];
    samples_per_segment_i = len[ADDR_W-1:0];
    step(4);
    check_eq("arm_o before arm", arm_o, 0);
    arm_i = 1'b1;
    step();
    check_eq("arm_o after arm", arm_o, 1);  // one edge after arm_i is seen
    step(2);
  endtask

  initial begin
    void'($urandom(32'hd2e7));
    err_cnt = 0;
    reset = 1'b1;
    trigger_i = 1'b0;
    trigger_level_i = 1'b1;
    trigger_wait_i = 1'b0;
    trigger_now_i = 1'b0;
    arm_i = 1'b0;
    trigger_offset_i = '0;
    adc_data_i = '0;
    num_segments_i = 5'd1;
    samples_per_segment_i = '0;
    host_op_i = host_pkg::OP_NOP;
    host_addr_i = '0;
    step(10);
    reset = 1'b0;
    step(2);

    // level trigger, one segment, random offset
    lvl = 1'($urandom % 2);
    off = $urandom % 20;
    n   = 8 + $urandom % 24;
    start_capture(lvl, 1'b0, off, 1, n, ~lvl);
    trigger_i = lvl;
    e0 = edge_n + 1;
    wait_go(g);
    check_eq("capture_go_o edge", g, e0 + off + 1);
    check_eq("capture_active_o", capture_active_o, 1);
    record_segment(0, e0 + off + 1, n);
    step(1 + $urandom % 5);
    trigger_i = ~lvl;
    wait_idle(e0 + off + 1, n);
    step();
    verify_range(0, n);
    check_length();

    // several segments packed back to back
    segs = 2 + $urandom % (capture_pkg::MAX_SEGMENTS - 1);
    n   = 20 + $urandom % 40;
    off = $urandom % 20;
    lvl = 1'($urandom % 2);
    start_capture(lvl, 1'b0, off, segs, n, ~lvl);
    for (s = 0; s < segs; s++) begin
      trigger_i = lvl;
      e0 = edge_n + 1;
      wait_go(g);
      check_eq($sformatf("capture_go_o edge seg %0d", s), g, e0 + off + 1);
      check_eq("capture_active_o", capture_active_o, 1);
      record_segment(s * n, e0 + off + 1, n);
      if (s == segs - 1) begin
        wait_idle(e0 + off + 1, n);
        step();
      end else begin
        step(n + 4);  // burst finished before the retrigger
      end
      trigger_i = ~lvl;
      step(2);
    end
    used_top = segs * n;
    verify_range(0, used_top);
    check_length();

    // wait mode, trigger already active at arm time
    lvl = 1'($urandom % 2);
    off = $urandom % 20;
    n   = 8 + $urandom % 16;
    start_capture(lvl, 1'b1, off, 1, n, lvl);
    for (i = 0; i < 12; i++) begin
      step();
      check_eq("capture_go_o while waiting", capture_go_o, 0);
      check_eq("capture_active_o while waiting", capture_active_o, 0);
    end
    trigger_i = ~lvl;
    step(2);
    trigger_i = lvl;
    e0 = edge_n + 1;
    wait_go(g);
    check_eq("capture_go_o edge after wait", g, e0 + off + 1);
    record_segment(0, e0 + off + 1, n);
    wait_idle(e0 + off + 1, n);
    step();
    trigger_i = ~lvl;
    step();
    verify_range(0, n);
    check_length();

    // force strobe, trigger line never active
    lvl = 1'($urandom % 2);
    off = $urandom % 20;
    n   = 8 + $urandom % 16;
    start_capture(lvl, 1'b0, off, 1, n, ~lvl);
    trigger_now_i = 1'b1;
    e0 = edge_n + 4;  // three stage strobe pipe plus edge detect
    step();
    trigger_now_i = 1'b0;
    wait_go(g);
    check_eq("capture_go_o edge on force", g, e0 + off + 1);
    record_segment(0, e0 + off + 1, n);
    wait_idle(e0 + off + 1, n);
    step();
    verify_range(0, n);
    check_length();

    // host sample reads racing a burst
    lvl = 1'($urandom % 2);
    off = $urandom % 10;
    n   = 16;
    start_capture(lvl, 1'b0, off, 1, n, ~lvl);
    fork
      begin
        trigger_i = lvl;
        e0 = edge_n + 1;
        wait_go(g);
        check_eq("capture_go_o edge", g, e0 + off + 1);
        record_segment(0, e0 + off + 1, n);
        wait_idle(e0 + off + 1, n);
      end
      begin
        step(off + 3);  // op lands while the writer owns the buffer
        for (i = 0; i < 4; i++) begin
          a = n + $urandom % (used_top - n);
          host_read(host_pkg::OP_READ_SAMPLE, a, d, lat);
          check_eq($sformatf("host_rdata_o[%0d]", a), d, exp_mem[a]);
          if (i == 0)
            check_eq("first read stalled by writer", lat > 3, 1);
        end
      end
    join
    step();
    trigger_i = ~lvl;
    step();
    verify_range(0, n);
    check_length();

    arm_i = 1'b0;
    step(4);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_scope_capture_assert.sv ====
`timescale 1ns/1ps

module tb_scope_capture_assert (
  input logic               adc_clk,
  input logic               reset,
  input logic               arm_i,
  input logic               capture_go_o,
  input logic               host_rvalid_o,
  input host_pkg::host_op_e host_op_i
);

  // go is a single cycle strobe
  go_single_a: assert property (@(posedge adc_clk) disable iff (reset)
    capture_go_o |=> !capture_go_o)
    else $error("capture_go_o high two cycles in a row");

  go_armed_a: assert property (@(posedge adc_clk) disable iff (reset)
    capture_go_o |-> arm_i)  // offset counter gated by arm
    else $error("capture_go_o pulsed with arm_i low");

  // op is still held in the rvalid cycle
  rvalid_op_a: assert property (@(posedge adc_clk) disable iff (reset)
    host_rvalid_o |-> (host_op_i != host_pkg::OP_NOP))
    else $error("host_rvalid_o without a pending host op");

endmodule

bind scope_capture_top tb_scope_capture_assert tb_scope_capture_assert_i (.*);

// ==== trigger_unit.sv ====
`timescale 1ns/1ps

module trigger_unit (
  input  logic        adc_clk,
  input  logic        reset,
  input  logic        trigger_i,         // trigger line, already synchronous
  input  logic        trigger_level_i,   // 1 = high or rising, 0 = low or falling
  input  logic        trigger_wait_i,    // see inactive level before arming
  input  logic        trigger_now_i,     // force strobe
  input  logic        arm_i,             // rising edge starts a fresh arm
  input  logic [31:0] trigger_offset_i,  // go delay in adc cycles
  input  logic        capture_done_i,    // from writer, ends the capture
  output logic        arm_o,
  output logic        capture_active_o,
  output logic        capture_go_o,
  output logic [31:0] trigger_length_o
);

  logic        armed;
  logic        trig_hit;      // trigger at its active level
  logic        arm_i_dly;
  logic        arm_rise;
  logic [1:0]  now_pipe;      // sync stages on the force strobe
  logic        now_r;
  logic        now_r2;
  logic        trigger_now;   // single-cycle force event
  logic        go_start;      // offset delay running
  logic        triggered;     // go issued, waiting for trigger to drop
  logic        disarm;
  logic        capture_clr;
  logic [31:0] delay_cnt;

  assign trig_hit    = (trigger_i == trigger_level_i);
  assign arm_rise    = arm_i & ~arm_i_dly;
  assign trigger_now = now_r & ~now_r2;  // rising edge of force
  assign capture_clr = reset | capture_done_i | ~arm_i;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      now_pipe  <= '0;
      now_r     <= 1'b0;
      now_r2    <= 1'b0;
      arm_i_dly <= 1'b0;
    end else begin
      {now_r2, now_r, now_pipe} <= {now_r, now_pipe, trigger_now_i};
      arm_i_dly <= arm_i;
    end
  end

  // disarm once fired and hold until arm drops and capture ends
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      disarm <= 1'b0;
    end else if ((trig_hit & armed) | trigger_now) begin
      disarm <= 1'b1;
    end else if (!arm_i && !capture_active_o) begin
      disarm <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset | disarm) begin
      arm_o <= 1'b0;
      armed <= 1'b0;
    end else begin
      if (arm_i)
        arm_o <= 1'b1;  // raw arm status
      if (arm_o && (!trig_hit || !trigger_wait_i))
        armed <= 1'b1;  // ready for the trigger
    end
  end

  always_ff @(posedge adc_clk) begin
    if (capture_clr) begin
      capture_active_o <= 1'b0;
      go_start         <= 1'b0;
      triggered        <= 1'b0;
    end else begin
      if ((trig_hit & armed) | trigger_now)
        capture_active_o <= 1'b1;
      if (((trig_hit & (capture_active_o | armed)) | trigger_now) & ~triggered)
        go_start <= 1'b1;  // new segment request
      else if (capture_go_o)
        go_start <= 1'b0;
      if (go_start)
        triggered <= 1'b1;
      else if (!trig_hit)
        triggered <= 1'b0;  // retrigger needs the inactive level first
    end
  end

  // go fires when the delay count reaches the offset
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      delay_cnt    <= '0;
      capture_go_o <= 1'b0;
    end else begin
      capture_go_o <= 1'b0;
      if (arm_rise) begin
        delay_cnt <= '0;  // stale count from an earlier capture
      end else if (go_start && !capture_go_o && arm_i) begin
        if (delay_cnt == trigger_offset_i) begin
          delay_cnt    <= '0;
          capture_go_o <= 1'b1;
        end else begin
          delay_cnt <= delay_cnt + 32'd1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset || arm_rise)
      trigger_length_o <= '0;
    else if (trig_hit)
      trigger_length_o <= trigger_length_o + 32'd1;  // cycles at active level
  end

endmodule
